// File: rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

	parameter int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0]      reg_t;

	// only the integer ALU classes and lui
	typedef enum logic [6:0] {
		op_reg = 7'b0110011,
		op_imm = 7'b0010011,
		op_lui = 7'b0110111
	} opcode_t;

	// low bits are funct3, top bit is instr[30]
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_op_t;

	typedef struct packed {
		logic [6:0] funct7;
		reg_t       rs2;
		reg_t       rs1;
		logic [2:0] funct3;
		reg_t       rd;
		opcode_t    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_t        rs1;
		logic [2:0]  funct3;
		reg_t        rd;
		opcode_t     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [19:0] imm; // upper 20 bits of the result
		reg_t        rd;
		opcode_t     opcode;
	} u_fmt_t;

	// one fetched word, viewed per format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		u_fmt_t u;
	} instr_u;

endpackage

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	import rv32i_pkg::*;

	// control carried from decode into execute
	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm; // operand b from immediate
		logic    lui;     // result is the immediate
		reg_t    rd;
		logic    wr_en;   // writes a nonzero rd
		logic    valid;
	} ex_ctrl_t;

	typedef struct packed {
		ex_ctrl_t ctrl;
		reg_t     rs1;
		reg_t     rs2;
		word_t    rs1_data;
		word_t    rs2_data;
		word_t    imm;
	} id_ex_t;

	// result record for ex/mem, mem/wb and the wb port
	typedef struct packed {
		logic  valid;
		reg_t  rd;
		word_t data;
	} retire_t;

	typedef enum logic [1:0] {
		fwd_none,
		fwd_ex_mem,
		fwd_mem_wb
	} fwd_sel_t;

endpackage

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv32i_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  run,
	input  wire word_t instr,
	output word_t      instr_addr,
	output instr_u     if_id_instr,
	output logic       if_id_valid
);

	word_t pc;

	assign instr_addr = pc; // imem answers in the same cycle

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= RESET_PC;
			if_id_valid <= 1'b0;
		end else if (run) begin
			pc          <= pc + word_t'(4);
			if_id_valid <= 1'b1;
			if_id_instr <= instr;
		end
	end

endmodule

`default_nettype wire

// File: decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv32i_pkg::*, pipe_pkg::*; (
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   run,
	input  wire instr_u if_id_instr,
	input  wire logic   if_id_valid,
	input  wire word_t  rs1_data,
	input  wire word_t  rs2_data,
	output reg_t        rs1,
	output reg_t        rs2,
	output id_ex_t      id_ex
);

	id_ex_t id_ex_d;
	logic   alt;   // instr[30], picks sub or sra
	logic   known;

	// register fields sit in the same place for every format used here
	assign rs1 = if_id_instr.r.rs1;
	assign rs2 = if_id_instr.r.rs2;
	assign alt = if_id_instr.r.funct7[5];

	always_comb begin
		id_ex_d = '0;
		known   = 1'b1;
		case (if_id_instr.r.opcode)
			op_reg: begin
				id_ex_d.ctrl.alu_op = alu_op_t'({
					alt && (if_id_instr.r.funct3 inside {3'b000, 3'b101}),
					if_id_instr.r.funct3});
			end
			op_imm: begin
				// srai is the only immediate op that looks at bit 30
				id_ex_d.ctrl.alu_op  = alu_op_t'({alt && (if_id_instr.i.funct3 == 3'b101),
					if_id_instr.i.funct3});
				id_ex_d.ctrl.use_imm = 1'b1;
				id_ex_d.imm = {{(XLEN-12){if_id_instr.i.imm[11]}}, if_id_instr.i.imm};
			end
			op_lui: begin
				id_ex_d.ctrl.lui     = 1'b1;
				id_ex_d.ctrl.use_imm = 1'b1;
				id_ex_d.imm          = {if_id_instr.u.imm, 12'b0};
			end
			default: known = 1'b0; // unsupported, retires nothing
		endcase
		id_ex_d.ctrl.rd    = if_id_instr.r.rd;
		id_ex_d.ctrl.valid = if_id_valid;
		id_ex_d.ctrl.wr_en = known && (if_id_instr.r.rd != '0);
		id_ex_d.rs1        = rs1;
		id_ex_d.rs2        = rs2;
		id_ex_d.rs1_data   = rs1_data;
		id_ex_d.rs2_data   = rs2_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			id_ex.ctrl <= '0;
		else if (run)
			id_ex <= id_ex_d;
	end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import rv32i_pkg::*, pipe_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire reg_t    rs1,
	input  wire reg_t    rs2,
	input  wire retire_t wb,
	output word_t        rs1_data,
	output word_t        rs2_data
);

	word_t regs [1:31]; // x0 has no storage

	function automatic word_t read_reg(reg_t r);
		if (r == '0)
			return '0;
		if (wb.valid && wb.rd == r)
			return wb.data; // writeback bypass
		return regs[r];
	endfunction

	always_comb begin
		rs1_data = read_reg(rs1);
		rs2_data = read_reg(rs2);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb.valid && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

endmodule

`default_nettype wire

// File: forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit import rv32i_pkg::*, pipe_pkg::*; (
	input  wire id_ex_t  id_ex,
	input  wire retire_t ex_mem,
	input  wire retire_t wb,
	output fwd_sel_t     fwd_a,
	output fwd_sel_t     fwd_b
);

	// the younger result wins when both stages hold the same rd
	function automatic fwd_sel_t src_of(reg_t r, retire_t near, retire_t far);
		if (near.valid && near.rd == r)
			return fwd_ex_mem;
		if (far.valid && far.rd == r)
			return fwd_mem_wb;
		return fwd_none;
	endfunction

	assign fwd_a = src_of(id_ex.rs1, ex_mem, wb);

	// i-type and lui read no rs2
	assign fwd_b = id_ex.ctrl.use_imm ? fwd_none : src_of(id_ex.rs2, ex_mem, wb);

endmodule

`default_nettype wire

// File: exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module exec_pipe import rv32i_pkg::*, pipe_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst_n,
	input  wire logic     run,
	input  wire id_ex_t   id_ex,
	input  wire fwd_sel_t fwd_a,
	input  wire fwd_sel_t fwd_b,
	output retire_t       ex_mem,
	output retire_t       wb
);

	word_t   op_a;
	word_t   op_b;
	word_t   alu_y;
	retire_t ex_mem_d;
	retire_t mem_wb;

	always_comb begin
		case (fwd_a)
			fwd_ex_mem: op_a = ex_mem.data;
			fwd_mem_wb: op_a = wb.data;
			default:    op_a = id_ex.rs1_data;
		endcase
		if (id_ex.ctrl.use_imm)
			op_b = id_ex.imm;
		else if (fwd_b == fwd_ex_mem)
			op_b = ex_mem.data;
		else if (fwd_b == fwd_mem_wb)
			op_b = wb.data;
		else
			op_b = id_ex.rs2_data;
	end

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_add:  alu_y = op_a + op_b;
			alu_sub:  alu_y = op_a - op_b;
			alu_sll:  alu_y = op_a << op_b[4:0];
			alu_slt:  alu_y = word_t'($signed(op_a) < $signed(op_b));
			alu_sltu: alu_y = word_t'(op_a < op_b);
			alu_xor:  alu_y = op_a ^ op_b;
			alu_srl:  alu_y = op_a >> op_b[4:0];
			alu_sra:  alu_y = word_t'($signed(op_a) >>> op_b[4:0]);
			alu_or:   alu_y = op_a | op_b;
			alu_and:  alu_y = op_a & op_b;
			default:  alu_y = op_a + op_b;
		endcase
		ex_mem_d.valid = id_ex.ctrl.valid && id_ex.ctrl.wr_en;
		ex_mem_d.rd    = id_ex.ctrl.rd;
		ex_mem_d.data  = id_ex.ctrl.lui ? id_ex.imm : alu_y; // lui skips the alu
	end

	// mem stage has no access, the record just moves on
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.valid <= 1'b0;
			mem_wb.valid <= 1'b0;
		end else if (run) begin
			ex_mem <= ex_mem_d;
			mem_wb <= ex_mem;
		end
	end

	always_comb begin
		wb       = mem_wb;
		wb.valid = mem_wb.valid && run; // no write while held
	end

endmodule

`default_nettype wire

// File: rv32i_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_pipeline import rv32i_pkg::*, pipe_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input  wire logic  clk,
	input  wire logic  rst_n,
	input  wire logic  run,
	output word_t      instr_addr,
	input  wire word_t instr,
	output retire_t    wb
);

	instr_u   if_id_instr;
	logic     if_id_valid;
	reg_t     rs1;
	reg_t     rs2;
	word_t    rs1_data;
	word_t    rs2_data;
	id_ex_t   id_ex;
	retire_t  ex_mem;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;

	fetch_unit #(
		.RESET_PC(RESET_PC)
	) i_fetch (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.if_id_instr (if_id_instr),
		.if_id_valid (if_id_valid)
	);

	decode_unit i_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.run         (run),
		.if_id_instr (if_id_instr),
		.if_id_valid (if_id_valid),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.rs1         (rs1),
		.rs2         (rs2),
		.id_ex       (id_ex)
	);

	regfile i_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.wb       (wb),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	forwarding_unit i_fwd (
		.id_ex  (id_ex),
		.ex_mem (ex_mem),
		.wb     (wb),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b)
	);

	exec_pipe i_exec (
		.clk    (clk),
		.rst_n  (rst_n),
		.run    (run),
		.id_ex  (id_ex),
		.fwd_a  (fwd_a),
		.fwd_b  (fwd_b),
		.ex_mem (ex_mem),
		.wb     (wb)
	);

endmodule

`default_nettype wire

// File: rv32i_pipeline_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_pipeline_chk import rv32i_pkg::*, pipe_pkg::*; (
	input wire logic    clk,
	input wire logic    rst_n,
	input wire logic    run,
	input wire word_t   instr_addr,
	input wire retire_t wb
);

	// mem/wb is cleared on the first reset edge
	a_no_wb_in_reset: assert property (@(posedge clk) !rst_n |=> !wb.valid)
		else $error("wb.valid high while reset is applied");

	a_no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n)
		wb.valid |-> wb.rd != '0)
		else $error("result retired to x0");

	a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
		run |=> instr_addr == $past(instr_addr) + 32'd4)
		else $error("pc did not advance by 4 while running");

endmodule

bind rv32i_pipeline rv32i_pipeline_chk i_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.run        (run),
	.instr_addr (instr_addr),
	.wb         (wb)
);

`default_nettype wire

// File: tb_rv32i_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_pipeline
	import rv32i_pkg::*, pipe_pkg::*;
();

	localparam word_t reset_pc = 32'h0000_0100;
	localparam word_t nop_word = 32'h0000_0013; // addi x0, x0, 0

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic        run = 1'b0;
	word_t       instr_addr;
	word_t       instr;
	retire_t     wb;
	word_t       imem [0:127];
	int          prog_len = 0;
	word_t       prog_q [$];
	retire_t     exp_q [$];
	retire_t     got_q [$];
	int          n_mismatch = 0;
	int          n_count = 0;
	int          n_other = 0;
	int          budget = 0; // watchdog limit in cycles
	int          cycles = 0;
	int unsigned seed = 56100;

	rv32i_pipeline #(
		.RESET_PC(reset_pc)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.instr_addr (instr_addr),
		.instr      (instr),
		.wb         (wb)
	);

	always #50 clk = ~clk;

	// instruction memory, answers in the same cycle
	always_comb begin
		instr = nop_word;
		if (instr_addr >= reset_pc && ((instr_addr - reset_pc) >> 2) < prog_len)
			instr = imem[(instr_addr - reset_pc) >> 2];
	end

	always @(posedge clk) begin
		if (wb.valid) begin
			if (!rst_n) begin
				n_other++;
				$display("a result retired while reset was applied");
			end
			if (wb.rd == '0) begin
				n_other++;
				$display("a result retired to x0");
			end
			got_q.push_back(wb);
		end
	end

	// budget grows as each program is loaded
	initial begin
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the pipeline did not drain", cycles);
		print_counts();
		$display("Verification failed");
		$finish;
	end

	function automatic word_t rtype_word(logic [6:0] f7, reg_t rs2, reg_t rs1,
			logic [2:0] f3, reg_t rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic word_t itype_word(logic [11:0] imm, reg_t rs1, logic [2:0] f3, reg_t rd);
		return {imm, rs1, f3, rd, op_imm};
	endfunction

	function automatic word_t lui_word(logic [19:0] imm, reg_t rd);
		return {imm, rd, op_lui};
	endfunction

	task automatic load_const(reg_t rd, word_t v);
		word_t hi;
		hi = v + 32'h800; // addi sign-extends the low part
		prog_q.push_back(lui_word(hi[31:12], rd));
		prog_q.push_back(itype_word(v[11:0], rd, 3'b000, rd));
	endtask

	// in-order ISA model of the loaded program
	task automatic golden_results();
		word_t gr [0:31];
		word_t w;
		word_t a;
		word_t b;
		word_t y;
		logic  alt;
		foreach (gr[i]) gr[i] = '0;
		exp_q.delete();
		foreach (prog_q[n]) begin
			w   = prog_q[n];
			a   = gr[w[19:15]];
			b   = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : gr[w[24:20]];
			alt = w[30] && (w[14:12] == 3'b101 || w[6:0] == 7'b0110011);
			case (w[14:12])
				3'd0: y = alt ? a - b : a + b;
				3'd1: y = a << b[4:0];
				3'd2: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				3'd3: y = (a < b) ? 32'd1 : 32'd0;
				3'd4: y = a ^ b;
				3'd5: y = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
				3'd6: y = a | b;
				default: y = a & b;
			endcase
			if (w[6:0] == 7'b0110111)
				y = {w[31:12], 12'h000};
			if (w[6:0] inside {7'b0110011, 7'b0010011, 7'b0110111} && w[11:7] != 5'd0) begin
				gr[w[11:7]] = y;
				exp_q.push_back({1'b1, w[11:7], y});
			end
		end
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (act !== exp) begin
			n_mismatch++;
			$display("mismatch in %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_reg(string name, reg_t exp, reg_t act);
		if (act !== exp) begin
			n_mismatch++;
			$display("mismatch in %s: expected x%0d, actual x%0d", name, exp, act);
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			n_mismatch++;
			$display("mismatch in %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_retire(string name, retire_t exp, retire_t act);
		check_reg({name, " rd"}, exp.rd, act.rd);
		check_word({name, " data"}, exp.data, act.data);
	endtask

	task automatic reset_and_load();
		golden_results();
		budget += prog_q.size() + 40;
		@(negedge clk);
		rst_n = 1'b0;
		run   = 1'b1;
		foreach (prog_q[n]) imem[n] = prog_q[n];
		prog_len = prog_q.size();
		repeat (4) @(posedge clk);
		@(negedge clk);
		got_q.delete();
		rst_n = 1'b1;
	endtask

	task automatic drain_and_compare(string name);
		// last result is written once the pc is five words past it
		while (instr_addr < reset_pc + 4 * (prog_len + 5))
			@(negedge clk);
		if (got_q.size() != exp_q.size()) begin
			n_count++;
			$display("%s: %0d results retired, %0d expected", name, got_q.size(), exp_q.size());
		end
		foreach (exp_q[n])
			if (n < got_q.size())
				check_retire($sformatf("%s result %0d", name, n), exp_q[n], got_q[n]);
	endtask

	task automatic fetch_after_reset();
		int n;
		prog_q.delete();
		prog_q.push_back(itype_word(12'h123, 5'd0, 3'b000, 5'd1));
		prog_q.push_back(itype_word(12'h001, 5'd1, 3'b000, 5'd2));
		prog_q.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		reset_and_load();
		check_word("reset pc", reset_pc, instr_addr);
		check_flag("reset wb valid", 1'b0, wb.valid);
		n = 0;
		while (!wb.valid && n < 8) begin
			@(negedge clk);
			n++;
		end
		check_word("first retire latency", 4, n);
		drain_and_compare("fetch_after_reset");
	endtask

	task automatic imm_alu_ops();
		logic [2:0]  f3s [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
		logic [11:0] imm;
		reg_t        rd;
		prog_q.delete();
		load_const(5'd1, $urandom());
		load_const(5'd2, $urandom() | 32'h8000_0000); // negative source
		rd = 5'd3;
		for (int s = 1; s <= 2; s++)
			for (int k = 0; k < 9; k++) begin
				imm = 12'($urandom());
				if (f3s[k] inside {3'd1, 3'd5})
					imm = {(k == 8) ? 7'b0100000 : 7'b0000000, imm[4:0]}; // srai sets bit 30
				prog_q.push_back(itype_word(imm, reg_t'(s), f3s[k], rd));
				rd++;
			end
		reset_and_load();
		drain_and_compare("imm_alu_ops");
	endtask

	task automatic reg_alu_hazards();
		logic [2:0] f3s [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
		logic [6:0] f7s [10] = '{0, 7'h20, 0, 0, 0, 0, 0, 7'h20, 0, 0};
		prog_q.delete();
		load_const(5'd5, $urandom());
		load_const(5'd7, $urandom());
		for (int f = 0; f < 10; f++)
			for (int d = 1; d <= 3; d++) begin
				prog_q.push_back(itype_word(12'($urandom()), 5'd5, 3'b000, 5'd5));
				if (d == 1) // ex/mem and mem/wb both hold x5
					prog_q.push_back(itype_word(12'($urandom()), 5'd5, 3'b000, 5'd5));
				repeat (d - 1)
					prog_q.push_back(itype_word(12'(d), 5'd0, 3'b000, 5'd9));
				if ((f + d) % 2 == 0)
					prog_q.push_back(rtype_word(f7s[f], 5'd7, 5'd5, f3s[f], 5'd6));
				else
					prog_q.push_back(rtype_word(f7s[f], 5'd5, 5'd7, f3s[f], 5'd6));
			end
		reset_and_load();
		drain_and_compare("reg_alu_hazards");
	endtask

	task automatic x0_and_lui();
		prog_q.delete();
		load_const(5'd1, $urandom());
		prog_q.push_back(itype_word(12'h07b, 5'd1, 3'b000, 5'd0));
		prog_q.push_back(lui_word(20'($urandom()), 5'd0));
		prog_q.push_back(rtype_word(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
		prog_q.push_back(rtype_word(7'h00, 5'd1, 5'd0, 3'b000, 5'd10)); // x0 + x1
		prog_q.push_back(rtype_word(7'h00, 5'd0, 5'd0, 3'b110, 5'd11));
		prog_q.push_back(lui_word(20'($urandom()), 5'd12));
		prog_q.push_back(lui_word(20'hfffff, 5'd13));
		prog_q.push_back(itype_word(12'h000, 5'd0, 3'b000, 5'd14));
		reset_and_load();
		drain_and_compare("x0_and_lui");
	endtask

	task automatic run_hold();
		word_t held;
		prog_q.delete();
		load_const(5'd1, $urandom());
		load_const(5'd2, $urandom());
		prog_q.push_back(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3)); // add
		prog_q.push_back(rtype_word(7'h20, 5'd1, 5'd3, 3'b000, 5'd4)); // sub
		prog_q.push_back(rtype_word(7'h00, 5'd3, 5'd4, 3'b100, 5'd5));
		prog_q.push_back(rtype_word(7'h20, 5'd2, 5'd5, 3'b101, 5'd6)); // sra
		prog_q.push_back(rtype_word(7'h00, 5'd1, 5'd6, 3'b010, 5'd7));
		prog_q.push_back(itype_word(12'hffb, 5'd7, 3'b000, 5'd8));
		prog_q.push_back(rtype_word(7'h00, 5'd5, 5'd8, 3'b110, 5'd9));
		prog_q.push_back(rtype_word(7'h00, 5'd4, 5'd9, 3'b111, 5'd10));
		reset_and_load();
		while (got_q.size() < 3 && instr_addr < reset_pc + 64)
			@(negedge clk);
		run  = 1'b0;
		held = instr_addr;
		repeat (6) begin
			@(negedge clk);
			check_word("run_hold pc", held, instr_addr);
			check_flag("run_hold wb valid", 1'b0, wb.valid);
		end
		run = 1'b1;
		drain_and_compare("run_hold");
	endtask

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d retirement count errors, %0d other",
			n_mismatch, n_count, n_other);
	endtask

	initial begin
		void'($urandom(seed));
		fetch_after_reset();
		imm_alu_ops();
		reg_alu_hazards();
		x0_and_lui();
		run_hold();
		print_counts();
		if (n_mismatch + n_count + n_other == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
rv32i_pkg.sv
pipe_pkg.sv
fetch_unit.sv
decode_unit.sv
regfile.sv
forwarding_unit.sv
exec_pipe.sv
rv32i_pipeline.sv
rv32i_pipeline_chk.sv
tb_rv32i_pipeline.sv
